//--- src/lb_defines.svh
// Local bus widths and address map
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// Bus widths
`define LB_AW 24
`define LB_DW 32

// Default sizes of the mirror memory and the PWM counter
`define MIRROR_AW 5
`define LED_CW 10

// Address spaces, taken from addr[23:16]
`define SPACE_REGS 8'h00
`define SPACE_LOCAL 8'h05

// Direct write offsets within the local space
`define REG_LED_USER 5'd1
`define REG_LED1_DF 5'd2
`define REG_LED2_DF 5'd3
`define REG_MISC 5'd8

// Words returned where nothing is mapped
`define FILL_UNMAPPED 32'hdeadbeef
`define FILL_BANK "zzzz"

`endif

//--- src/lb_pkg.sv
// Local bus types
`include "lb_defines.svh"

package lb_pkg;

	// Bus address and data word
	typedef logic [`LB_AW-1:0] lb_addr_t;
	typedef logic [`LB_DW-1:0] lb_data_t;

	// Address space, the top byte of the address
	typedef logic [7:0] lb_space_t;

	// LED duty factor, scaled by four against the PWM counter
	typedef logic [7:0] duty_t;

	// Board configuration byte
	typedef logic [7:0] misc_cfg_t;

endpackage

//--- src/lb_if.sv
// Local bus interface
`timescale 1ns/1ns

interface lb_if import lb_pkg::*; ();

	// Address, strobe and read flag come from the host each cycle
	lb_addr_t addr;
	logic strobe;
	logic rd;
	lb_data_t wdata;

	// All slave blocks only watch the bus
	modport slave (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

endinterface

//--- src/lb_mirror_ram.sv
// Local write mirror memory
`timescale 1ns/1ns
`include "lb_defines.svh"

module lb_mirror_ram import lb_pkg::*; #(
	parameter int aw = `MIRROR_AW
)(
	input logic clk,
	lb_if.slave bus,
	output lb_data_t mirror_word
);

	lb_data_t mem [0:(1 << aw) - 1];
	logic local_write;

	// Every write to the local space lands here as well
	assign local_write = bus.strobe & ~bus.rd & (bus.addr[23:16] == `SPACE_LOCAL);

	// Port A writes, port B reads the same offset into a register every cycle
	always_ff @(posedge clk) begin
		if (local_write) begin
			mem[bus.addr[aw-1:0]] <= bus.wdata;
		end
		mirror_word <= mem[bus.addr[aw-1:0]];
	end

	// Host must present a clean address whenever it strobes
	a_addr_known: assert property (@(posedge clk)
		bus.strobe |-> !$isunknown(bus.addr))
		else $error("lb_mirror_ram: unknown address during strobe");

endmodule

//--- src/led_pwm.sv
// LED PWM generator
`timescale 1ns/1ns
`include "lb_defines.svh"

module led_pwm import lb_pkg::*; #(
	parameter int cw = `LED_CW
)(
	input logic clk,
	input logic rst,
	input duty_t led1_df,
	input duty_t led2_df,
	output logic led1,
	output logic led2,
	output logic tick
);

	logic [cw-1:0] cnt;
	logic [cw-1:0] led1_thr;
	logic [cw-1:0] led2_thr;

	// Duty factor times four, sized to the counter
	assign led1_thr = cw'({led1_df, 2'b00});
	assign led2_thr = cw'({led2_df, 2'b00});

	// Free-running counter, carry out is the wrap tick
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			{tick, cnt} <= {1'b0, cnt} + 1'b1;
		end
	end

	// Comparators, one cycle behind the duty registers
	always_ff @(posedge clk) begin
		if (rst) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= cnt < led1_thr;
			led2 <= cnt < led2_thr;
		end
	end

	// A zero duty must leave the LED dark on the following cycle
	a_led1_off: assert property (@(posedge clk) disable iff (rst)
		(led1_df == '0) |=> !led1)
		else $error("led_pwm: led1 lit with zero duty");

	a_led2_off: assert property (@(posedge clk) disable iff (rst)
		(led2_df == '0) |=> !led2)
		else $error("led_pwm: led2 lit with zero duty");

endmodule

//--- src/lb_reg_bank.sv
// Local bus register bank
`timescale 1ns/1ns
`include "lb_defines.svh"

module lb_reg_bank import lb_pkg::*; (
	input logic clk,
	input logic rst,
	lb_if.slave bus,
	input logic xdomain_fault,
	input logic tick,
	output lb_data_t bank_word,
	output logic led_user_mode,
	output duty_t led1_df,
	output duty_t led2_df,
	output misc_cfg_t misc_config
);

	// Identification string, four characters per word
	localparam lb_data_t HELLO_0 = "Hell";
	localparam lb_data_t HELLO_1 = "o wo";
	localparam lb_data_t HELLO_2 = "rld!";
	localparam lb_data_t HELLO_3 = "(::)";

	logic do_rd;
	logic local_write;
	logic [15:0] fault_count;
	logic [31:0] uptime;

	assign do_rd = bus.strobe & bus.rd;
	assign local_write = bus.strobe & ~bus.rd & (bus.addr[23:16] == `SPACE_LOCAL);

	// Direct writes, decoded by the low offset bits
	always_ff @(posedge clk) begin
		if (rst) begin
			led_user_mode <= 1'b0;
			led1_df <= '0;
			led2_df <= '0;
			misc_config <= '0;
		end else if (local_write) begin
			case (bus.addr[4:0])
				`REG_LED_USER: led_user_mode <= bus.wdata[0];
				`REG_LED1_DF: led1_df <= bus.wdata[7:0];
				`REG_LED2_DF: led2_df <= bus.wdata[7:0];
				`REG_MISC: misc_config <= bus.wdata[7:0];
				default: ;
			endcase
		end
	end

	// Fault pulses arrive already in the bus clock domain
	// Uptime advances once per PWM wrap
	always_ff @(posedge clk) begin
		if (rst) begin
			fault_count <= '0;
			uptime <= '0;
		end else begin
			if (xdomain_fault) begin
				fault_count <= fault_count + 1'b1;
			end
			if (tick) begin
				uptime <= uptime + 1'b1;
			end
		end
	end

	// First read stage
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (bus.addr[3:0])
				4'h0: bank_word <= HELLO_0;
				4'h1: bank_word <= HELLO_1;
				4'h2: bank_word <= HELLO_2;
				4'h3: bank_word <= HELLO_3;
				4'h4: bank_word <= {16'h0000, fault_count};
				4'h5: bank_word <= uptime;
				4'h6: bank_word <= {24'h000000, misc_config};
				default: bank_word <= `FILL_BANK;
			endcase
		end
	end

	// Strobe and read flag must be driven once reset has been released
	a_ctrl_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({bus.strobe, bus.rd}))
		else $error("lb_reg_bank: unknown strobe or rd");

endmodule

//--- src/lb_read_pipe.sv
// Local bus read pipeline, second stage
`timescale 1ns/1ns
`include "lb_defines.svh"

module lb_read_pipe import lb_pkg::*; (
	input logic clk,
	input logic rst,
	lb_if.slave bus,
	input lb_data_t bank_word,
	input lb_data_t mirror_word,
	output lb_data_t data_in
);

	logic do_rd;
	logic do_rd_r;
	lb_space_t space_r;

	assign do_rd = bus.strobe & bus.rd;

	// Hold the read flag and its space for one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	always_ff @(posedge clk) begin
		space_r <= bus.addr[23:16];
	end

	// Space select, data_in holds until the next read completes
	always_ff @(posedge clk) begin
		if (rst) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			case (space_r)
				`SPACE_REGS: data_in <= bank_word;
				`SPACE_LOCAL: data_in <= mirror_word;
				default: data_in <= `FILL_UNMAPPED;
			endcase
		end
	end

	// Both stages together must produce a defined word
	a_data_known: assert property (@(posedge clk) disable iff (rst)
		do_rd |=> ##1 !$isunknown(data_in))
		else $error("lb_read_pipe: unknown read data");

endmodule

//--- src/marble_lb_top.sv
// Marble local bus slave
`timescale 1ns/1ns

module marble_lb_top import lb_pkg::*; (
	input logic clk,
	input logic rst,
	input lb_addr_t addr,
	input logic strobe,
	input logic rd,
	input lb_data_t wdata,
	output lb_data_t data_in,
	input logic xdomain_fault,
	output logic led_user_mode,
	output logic led1,
	output logic led2,
	output misc_cfg_t misc_config
);

	lb_data_t bank_word;
	lb_data_t mirror_word;
	duty_t led1_df;
	duty_t led2_df;
	logic tick;

	lb_if bus ();

	// Host side of the bus
	assign bus.addr = addr;
	assign bus.strobe = strobe;
	assign bus.rd = rd;
	assign bus.wdata = wdata;

	lb_reg_bank regs (
		.clk(clk),
		.rst(rst),
		.bus(bus.slave),
		.xdomain_fault(xdomain_fault),
		.tick(tick),
		.bank_word(bank_word),
		.led_user_mode(led_user_mode),
		.led1_df(led1_df),
		.led2_df(led2_df),
		.misc_config(misc_config)
	);

	lb_mirror_ram mirror (
		.clk(clk),
		.bus(bus.slave),
		.mirror_word(mirror_word)
	);

	led_pwm pwm (
		.clk(clk),
		.rst(rst),
		.led1_df(led1_df),
		.led2_df(led2_df),
		.led1(led1),
		.led2(led2),
		.tick(tick)
	);

	lb_read_pipe rpipe (
		.clk(clk),
		.rst(rst),
		.bus(bus.slave),
		.bank_word(bank_word),
		.mirror_word(mirror_word),
		.data_in(data_in)
	);

endmodule

//--- testbench/tb_marble_lb.sv
// Local bus slave testbench
`timescale 1ns/1ns
`include "lb_defines.svh"

module tb_marble_lb import lb_pkg::*; ();

	localparam int PERIOD = 8;
	localparam logic [31:0] SEED = 32'h25b8_d47c;
	localparam int UPTIME_GAP = 3;
	// Rough length of each test in cycles, summed for the watchdog
	localparam int RUN_CYCLES = 30 + 80 + 20 + 60 + 3 * 1040 + (UPTIME_GAP + 1) * 1024 + 500;

	logic clk;
	logic rst;
	lb_addr_t addr;
	logic strobe;
	logic rd;
	lb_data_t wdata;
	lb_data_t data_in;
	logic xdomain_fault;
	logic led_user_mode;
	logic led1;
	logic led2;
	misc_cfg_t misc_config;

	lb_data_t exp_word;
	lb_data_t mirror_model [0:31];
	int unsigned cyc;
	int errors;
	int tests_passed;
	int tests_failed;

	marble_lb_top uut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.strobe(strobe),
		.rd(rd),
		.wdata(wdata),
		.data_in(data_in),
		.xdomain_fault(xdomain_fault),
		.led_user_mode(led_user_mode),
		.led1(led1),
		.led2(led2),
		.misc_config(misc_config)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Cycles since reset release, drives the uptime model
	always @(posedge clk) begin
		if (rst) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	task automatic flag_error(input string msg);
		errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	// Every read must return the model word two edges later
	a_read_data: assert property (@(posedge clk) disable iff (rst)
		(strobe && rd) |=> ##1 (data_in == $past(exp_word, 2)))
		else flag_error("data_in differs from the expected read word");

	task automatic close_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("ok     %s", name);
		end else begin
			tests_failed++;
			$display("error  %s (%0d mismatches)", name, errors - errors_before);
		end
	endtask

	// Every task starts and ends 1 ns after a rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		strobe = 1'b0;
		rd = 1'b0;
		repeat (n) step();
	endtask

	function automatic lb_addr_t regs_addr(input logic [3:0] off);
		return {`SPACE_REGS, 12'h000, off};
	endfunction

	function automatic lb_addr_t local_addr(input logic [4:0] off);
		return {`SPACE_LOCAL, 11'h000, off};
	endfunction

	task automatic bus_read(input lb_addr_t a, input lb_data_t expected);
		addr = a;
		strobe = 1'b1;
		rd = 1'b1;
		exp_word = expected;
		step();
		strobe = 1'b0;
		rd = 1'b0;
	endtask

	// Local writes also land in the mirror, so the model follows them
	task automatic local_write(input logic [4:0] off, input lb_data_t d);
		addr = local_addr(off);
		wdata = d;
		strobe = 1'b1;
		rd = 1'b0;
		step();
		strobe = 1'b0;
		mirror_model[off] = d;
	endtask

	task automatic read_id_words();
		int start;
		start = errors;
		bus_read(regs_addr(4'd0), "Hell");
		bus_read(regs_addr(4'd1), "o wo");
		bus_read(regs_addr(4'd2), "rld!");
		bus_read(regs_addr(4'd3), "(::)");
		bus_read(regs_addr(4'd7), `FILL_BANK);
		for (int s = 1; s < 5; s++) begin
			bus_read({8'(s), 16'h0000}, `FILL_UNMAPPED);
		end
		idle(3);
		close_test("identification and fill words", start);
	endtask

	task automatic readback_mirror();
		int start;
		logic [4:0] off;
		start = errors;
		for (int i = 16; i < 32; i++) begin
			local_write(5'(i), lb_data_t'($urandom));
		end
		repeat (6) begin
			off = {1'b1, 4'($urandom)};
			bus_read(local_addr(off), mirror_model[off]);
			idle(2);
		end
		// Back-to-back burst, one read per cycle
		for (int i = 16; i < 32; i++) begin
			bus_read(local_addr(5'(i)), mirror_model[i]);
		end
		idle(3);
		close_test("mirror memory readback", start);
	endtask

	task automatic set_control_regs();
		int start;
		misc_cfg_t cfg;
		start = errors;
		cfg = misc_cfg_t'($urandom) | 8'h01;
		local_write(`REG_MISC, 32'(cfg));
		assert (misc_config == cfg)
			else flag_error("misc_config pins differ from the written byte");
		bus_read(regs_addr(4'd6), {24'h000000, cfg});
		local_write(`REG_LED_USER, 32'h1);
		assert (led_user_mode == 1'b1)
			else flag_error("led_user_mode stayed low after the write");
		idle(3);
		close_test("control registers", start);
	endtask

	task automatic pulse_faults();
		int start;
		int pulses;
		start = errors;
		pulses = 5 + int'($urandom % 12);
		repeat (pulses) begin
			xdomain_fault = 1'b1;
			step();
			xdomain_fault = 1'b0;
			step();
		end
		bus_read(regs_addr(4'd4), 32'(pulses));
		idle(3);
		close_test("fault counter", start);
	endtask

	// Any 1024 samples cover one full PWM period
	task automatic measure_pwm(input duty_t duty1, input duty_t duty2);
		int high1;
		int high2;
		high1 = 0;
		high2 = 0;
		local_write(`REG_LED1_DF, 32'(duty1));
		local_write(`REG_LED2_DF, 32'(duty2));
		idle(2);
		repeat (1024) begin
			step();
			if (led1) begin
				high1++;
			end
			if (led2) begin
				high2++;
			end
		end
		assert (high1 == 4 * int'(duty1))
			else flag_error($sformatf("led1 high %0d cycles with duty %0d", high1, duty1));
		assert (high2 == 4 * int'(duty2))
			else flag_error($sformatf("led2 high %0d cycles with duty %0d", high2, duty2));
	endtask

	task automatic sweep_led_duty();
		int start;
		start = errors;
		measure_pwm(8'd0, 8'd255);
		measure_pwm(8'd255, 8'd0);
		measure_pwm(duty_t'($urandom), duty_t'($urandom));
		close_test("led duty cycles", start);
	endtask

	// Reads sit mid-period so the wrap edge never matters
	task automatic sample_uptime();
		int start;
		int unsigned first;
		start = errors;
		while (cyc % 1024 != 512) begin
			step();
		end
		first = cyc / 1024;
		bus_read(regs_addr(4'd5), 32'(first));
		idle(3);
		repeat (UPTIME_GAP * 1024 - 4) step();
		bus_read(regs_addr(4'd5), 32'(first + UPTIME_GAP));
		idle(3);
		close_test("uptime counter", start);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		addr = '0;
		strobe = 1'b0;
		rd = 1'b0;
		wdata = '0;
		xdomain_fault = 1'b0;
		exp_word = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(SEED));
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		step();
		read_id_words();
		readback_mirror();
		set_control_regs();
		pulse_faults();
		sweep_led_duty();
		sample_uptime();
		$display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(RUN_CYCLES * PERIOD);
		$display("Watchdog timeout: the tests did not finish within %0d cycles", RUN_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+src
src/lb_pkg.sv
src/lb_if.sv
src/lb_mirror_ram.sv
src/led_pwm.sv
src/lb_reg_bank.sv
src/lb_read_pipe.sv
src/marble_lb_top.sv
testbench/tb_marble_lb.sv

//--- Makefile
# Verilator build and run of the local bus slave testbench

VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_marble_lb
FILELIST = filelist.f
OBJ_DIR = obj_dir
PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run passes only if the pass message shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
